// ==== hw/ddr3_seq_pkg.sv ====
// Timing constants are fixed for a 50 MHz DDR3 clock, BL4 and a 32-bit DFI data path
package ddr3_seq_pkg;

    //----------------------------------------------------------------------
    // Clock and latency
    //----------------------------------------------------------------------
    localparam int DDR_MHZ        = 50;
    localparam int CYCLE_NS       = 1000 / DDR_MHZ;
    localparam int DDR_WR_LATENCY = 6;
    localparam int DDR_RD_LATENCY = 5;
    localparam int BURST_LEN      = 4;

    // DFI sees the command one cycle late, so latency shrinks by one
    localparam int PHY_WRLAT = DDR_WR_LATENCY - 1;
    localparam int PHY_RDLAT = DDR_RD_LATENCY - 1;

    //----------------------------------------------------------------------
    // Command spacing in clock cycles
    //----------------------------------------------------------------------
    // 15 ns rounded up
    localparam int TRCD_CYCLES = (15 + CYCLE_NS - 1) / CYCLE_NS;
    localparam int TRP_CYCLES  = (15 + CYCLE_NS - 1) / CYCLE_NS;
    // 260 ns rounded up
    localparam int TRFC_CYCLES = (260 + CYCLE_NS - 1) / CYCLE_NS;
    localparam int TWTR_CYCLES = 6;

    // Read/write turnaround
    localparam int RW_NONSEQ_CYCLES = DDR_WR_LATENCY + BURST_LEN + TWTR_CYCLES;
    // Same-type follow-on, burst lands right after the previous one
    localparam int RW_SEQ_CYCLES    = RW_NONSEQ_CYCLES + 1 - BURST_LEN;

    //----------------------------------------------------------------------
    // Write FIFO
    //----------------------------------------------------------------------
    localparam int WR_FIFO_DEPTH = 4;
    localparam int WR_FIFO_AW    = $clog2(WR_FIFO_DEPTH);

    //----------------------------------------------------------------------
    // Types
    //----------------------------------------------------------------------
    // Bit order is cs_n, ras_n, cas_n, we_n
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_ZQCL      = 4'b0110,
        CMD_NOP       = 4'b0111
    } cmd_t;

    typedef logic [14:0]  row_addr_t;
    typedef logic [2:0]   bank_t;
    typedef logic [31:0]  beat_t;
    typedef logic [3:0]   beat_mask_t;
    typedef logic [127:0] word_t;
    typedef logic [15:0]  word_mask_t;
    typedef logic [5:0]   delay_t;

    // One queued write, mask on top
    typedef struct packed {
        word_mask_t mask;
        word_t      data;
    } wr_entry_t;

endpackage

// ==== hw/ddr3_timer_if.sv ====
// Carries no clock; both ends must share the sequencer clock domain
interface ddr3_timer_if;

    import ddr3_seq_pkg::*;

    // Sequencer side
    logic   load;
    delay_t load_value;
    logic   early;

    // Timer side
    logic   expired;
    logic   at_seq_point;

    modport ctrl (
        output load,
        output load_value,
        output early,
        input  expired,
        input  at_seq_point
    );

    modport timer (
        input  load,
        input  load_value,
        input  early,
        output expired,
        output at_seq_point
    );

endinterface

// ==== hw/ddr3_delay_timer.sv ====
// Load is honoured only at zero; an early reload applies only while counting
module ddr3_delay_timer (
    input  logic         clk_i,
    input  logic         rst_i,
    ddr3_timer_if.timer  tmr_if
);

    import ddr3_seq_pkg::*;

    delay_t delay_q;
    logic   zero_w;

    assign zero_w = (delay_q == '0);

    //----------------------------------------------------------------------
    // Spacing counter
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            delay_q <= '0;
        end
        else if (zero_w)
        begin
            // Idle, start a new spacing window
            if (tmr_if.load)
                delay_q <= tmr_if.load_value;
        end
        else if (tmr_if.early)
        begin
            // Same-type R/W slipped in, restart turnaround
            delay_q <= delay_t'(RW_NONSEQ_CYCLES);
        end
        else
        begin
            delay_q <= delay_q - 1'b1;
        end
    end

    // Status back to the sequencer
    assign tmr_if.expired      = zero_w;
    assign tmr_if.at_seq_point = (delay_q == delay_t'(RW_SEQ_CYCLES));

endmodule

// ==== hw/ddr3_cmd_sequencer.sv ====
// User must hold a refused command; only NOP and same-type early R/W bypass the timer
module ddr3_cmd_sequencer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  ddr3_seq_pkg::cmd_t     command_i,
    input  ddr3_seq_pkg::row_addr_t address_i,
    input  ddr3_seq_pkg::bank_t    bank_i,
    input  logic                   cke_i,
    output logic                   accept_o,
    output logic                   wr_issue_o,
    output logic                   rd_issue_o,
    output logic                   dfi_cs_n_o,
    output logic                   dfi_ras_n_o,
    output logic                   dfi_cas_n_o,
    output logic                   dfi_we_n_o,
    output logic                   dfi_cke_o,
    output ddr3_seq_pkg::row_addr_t dfi_address_o,
    output ddr3_seq_pkg::bank_t    dfi_bank_o,
    ddr3_timer_if.ctrl             tmr_if
);

    import ddr3_seq_pkg::*;

    cmd_t      last_cmd_q;
    cmd_t      cmd_q;
    row_addr_t addr_q;
    bank_t     bank_q;
    logic      cke_q;
    logic      is_rw_w;
    logic      early_w;

    //----------------------------------------------------------------------
    // Acceptance
    //----------------------------------------------------------------------
    assign is_rw_w = (command_i == CMD_READ) || (command_i == CMD_WRITE);

    // READ after READ or WRITE after WRITE at the sequential point
    assign early_w = is_rw_w && (command_i == last_cmd_q) && tmr_if.at_seq_point;

    assign accept_o = tmr_if.expired || early_w || (command_i == CMD_NOP);

    assign wr_issue_o = accept_o && (command_i == CMD_WRITE);
    assign rd_issue_o = accept_o && (command_i == CMD_READ);

    // Last non-NOP command, used for the early check
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            last_cmd_q <= CMD_NOP;
        else if (accept_o && (command_i != CMD_NOP))
            last_cmd_q <= command_i;
    end

    //----------------------------------------------------------------------
    // Timer control
    //----------------------------------------------------------------------
    assign tmr_if.load  = accept_o;
    assign tmr_if.early = early_w;

    // Spacing by command class
    always_comb
    begin
        case (command_i)
            CMD_ACTIVE:    tmr_if.load_value = delay_t'(TRCD_CYCLES);
            CMD_PRECHARGE: tmr_if.load_value = delay_t'(TRP_CYCLES);
            CMD_REFRESH:   tmr_if.load_value = delay_t'(TRFC_CYCLES);
            CMD_READ,
            CMD_WRITE:     tmr_if.load_value = delay_t'(RW_NONSEQ_CYCLES);
            default:       tmr_if.load_value = '0;
        endcase
    end

    //----------------------------------------------------------------------
    // DFI command registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !accept_o)
        begin
            // Refused or idle, drive a clean NOP
            cmd_q  <= CMD_NOP;
            addr_q <= '0;
            bank_q <= '0;
        end
        else
        begin
            cmd_q  <= command_i;
            addr_q <= address_i;
            bank_q <= bank_i;
        end
    end

    // Clock enable, one cycle behind the user
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            cke_q <= 1'b0;
        else
            cke_q <= cke_i;
    end

    assign dfi_cs_n_o    = cmd_q[3];
    assign dfi_ras_n_o   = cmd_q[2];
    assign dfi_cas_n_o   = cmd_q[1];
    assign dfi_we_n_o    = cmd_q[0];
    assign dfi_cke_o     = cke_q;
    assign dfi_address_o = addr_q;
    assign dfi_bank_o    = bank_q;

endmodule

// ==== hw/ddr3_wr_fifo.sv ====
// Push when full and pop when empty are dropped silently; head is always visible
module ddr3_wr_fifo (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    push_i,
    input  logic                    pop_i,
    input  ddr3_seq_pkg::wr_entry_t data_i,
    output ddr3_seq_pkg::wr_entry_t data_o
);

    import ddr3_seq_pkg::*;

    wr_entry_t             mem_q [WR_FIFO_DEPTH];
    logic [WR_FIFO_AW-1:0] wr_ptr_q;
    logic [WR_FIFO_AW-1:0] rd_ptr_q;
    logic [WR_FIFO_AW:0]   count_q;
    logic                  do_push_w;
    logic                  do_pop_w;

    assign do_push_w = push_i && (count_q != (WR_FIFO_AW + 1)'(WR_FIFO_DEPTH));
    assign do_pop_w  = pop_i && (count_q != '0);

    // Storage
    always_ff @(posedge clk_i)
    begin
        if (do_push_w)
            mem_q[wr_ptr_q] <= data_i;
    end

    // Pointers wrap on the power-of-two depth
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (do_push_w)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (do_pop_w)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (do_push_w && !do_pop_w)
                count_q <= count_q + 1'b1;
            else if (!do_push_w && do_pop_w)
                count_q <= count_q - 1'b1;
        end
    end

    assign data_o = mem_q[rd_ptr_q];

endmodule

// ==== hw/ddr3_wr_path.sv ====
// Bursts closer than BURST_LEN cycles merge in the delay line; sequencer spacing prevents it
module ddr3_wr_path (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     wr_issue_i,
    input  ddr3_seq_pkg::word_t      wrdata_i,
    input  ddr3_seq_pkg::word_mask_t wrdata_mask_i,
    output ddr3_seq_pkg::beat_t      dfi_wrdata_o,
    output ddr3_seq_pkg::beat_mask_t dfi_wrdata_mask_o,
    output logic                     dfi_wrdata_en_o
);

    import ddr3_seq_pkg::*;

    localparam int WR_SHIFT_W = PHY_WRLAT + BURST_LEN;

    wr_entry_t              head_w;
    logic [WR_SHIFT_W-1:0]  wr_en_q;
    logic                   wr_en_w;
    logic [1:0]             beat_idx_q;
    logic                   pop_w;
    beat_t                  wrdata_q;
    beat_mask_t             wrmask_q;
    logic                   wrdata_en_q;

    //----------------------------------------------------------------------
    // Word queue
    //----------------------------------------------------------------------
    // Pop once the last slice has gone out
    assign pop_w = wr_en_w && (beat_idx_q == 2'd3);

    ddr3_wr_fifo u_wr_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .push_i (wr_issue_i),
        .pop_i  (pop_w),
        .data_i ('{mask: wrdata_mask_i, data: wrdata_i}),
        .data_o (head_w)
    );

    //----------------------------------------------------------------------
    // Write-enable delay line
    //----------------------------------------------------------------------
    // Four ones per write, older bits keep shifting below them
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            wr_en_q <= '0;
        else if (wr_issue_i)
            wr_en_q <= {{BURST_LEN{1'b1}}, wr_en_q[PHY_WRLAT:1]};
        else
            wr_en_q <= {1'b0, wr_en_q[WR_SHIFT_W-1:1]};
    end

    assign wr_en_w = wr_en_q[0];

    //----------------------------------------------------------------------
    // Beat serializer
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            beat_idx_q <= '0;
        else if (wr_en_w)
            beat_idx_q <= beat_idx_q + 1'b1;
    end

    // Low slice first, zero between bursts
    always_ff @(posedge clk_i)
    begin
        if (wr_en_w)
        begin
            wrdata_q <= head_w.data[{beat_idx_q, 5'd0} +: 32];
            wrmask_q <= head_w.mask[{beat_idx_q, 2'd0} +: 4];
        end
        else
        begin
            wrdata_q <= '0;
            wrmask_q <= '0;
        end
    end

    // Enable aligned with the registered beat
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            wrdata_en_q <= 1'b0;
        else
            wrdata_en_q <= wr_en_w;
    end

    assign dfi_wrdata_o      = wrdata_q;
    assign dfi_wrdata_mask_o = wrmask_q;
    assign dfi_wrdata_en_o   = wrdata_en_q;

endmodule

// ==== hw/ddr3_rd_path.sv ====
// Beat index counts every valid beat; a short burst from the PHY misaligns later words
module ddr3_rd_path (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                rd_issue_i,
    input  logic                dfi_rddata_valid_i,
    input  ddr3_seq_pkg::beat_t dfi_rddata_i,
    output logic                dfi_rddata_en_o,
    output ddr3_seq_pkg::word_t rddata_o,
    output logic                rddata_valid_o
);

    import ddr3_seq_pkg::*;

    localparam int RD_SHIFT_W = PHY_RDLAT + BURST_LEN;

    logic [RD_SHIFT_W-1:0] rd_en_q;
    logic                  rddata_en_q;
    logic [1:0]            beat_idx_q;
    word_t                 word_q;
    logic                  valid_q;

    //----------------------------------------------------------------------
    // Read-enable delay line
    //----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rd_en_q     <= '0;
            rddata_en_q <= 1'b0;
        end
        else
        begin
            if (rd_issue_i)
                rd_en_q <= {{BURST_LEN{1'b1}}, rd_en_q[PHY_RDLAT:1]};
            else
                rd_en_q <= {1'b0, rd_en_q[RD_SHIFT_W-1:1]};
            rddata_en_q <= rd_en_q[0];
        end
    end

    //----------------------------------------------------------------------
    // Beat assembler
    //----------------------------------------------------------------------
    // New beat enters at the top, first beat ends up lowest
    always_ff @(posedge clk_i)
    begin
        if (dfi_rddata_valid_i)
            word_q <= {dfi_rddata_i, word_q[127:32]};
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            beat_idx_q <= '0;
            valid_q    <= 1'b0;
        end
        else
        begin
            if (dfi_rddata_valid_i)
                beat_idx_q <= beat_idx_q + 1'b1;
            // Word complete after the fourth beat
            valid_q <= dfi_rddata_valid_i && (beat_idx_q == 2'd3);
        end
    end

    assign dfi_rddata_en_o = rddata_en_q;
    assign rddata_o        = word_q;
    assign rddata_valid_o  = valid_q;

endmodule

// ==== hw/ddr3_dfi_seq.sv ====
// Fixed 50 MHz timing; ODT and reset_n are left to the PHY wrapper
module ddr3_dfi_seq (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // User command side
    input  ddr3_seq_pkg::cmd_t        command_i,
    input  ddr3_seq_pkg::row_addr_t   address_i,
    input  ddr3_seq_pkg::bank_t       bank_i,
    input  logic                      cke_i,
    input  ddr3_seq_pkg::word_t       wrdata_i,
    input  ddr3_seq_pkg::word_mask_t  wrdata_mask_i,
    output logic                      accept_o,
    output ddr3_seq_pkg::word_t       rddata_o,
    output logic                      rddata_valid_o,

    // DFI side
    output ddr3_seq_pkg::row_addr_t   dfi_address_o,
    output ddr3_seq_pkg::bank_t       dfi_bank_o,
    output logic                      dfi_cs_n_o,
    output logic                      dfi_ras_n_o,
    output logic                      dfi_cas_n_o,
    output logic                      dfi_we_n_o,
    output logic                      dfi_cke_o,
    output ddr3_seq_pkg::beat_t       dfi_wrdata_o,
    output ddr3_seq_pkg::beat_mask_t  dfi_wrdata_mask_o,
    output logic                      dfi_wrdata_en_o,
    output logic                      dfi_rddata_en_o,
    input  ddr3_seq_pkg::beat_t       dfi_rddata_i,
    input  logic                      dfi_rddata_valid_i
);

    logic wr_issue;
    logic rd_issue;

    //----------------------------------------------------------------------
    // Command timing
    //----------------------------------------------------------------------
    ddr3_timer_if tmr_if ();

    ddr3_delay_timer u_delay_timer (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .tmr_if (tmr_if.timer)
    );

    ddr3_cmd_sequencer u_cmd_sequencer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .command_i     (command_i),
        .address_i     (address_i),
        .bank_i        (bank_i),
        .cke_i         (cke_i),
        .accept_o      (accept_o),
        .wr_issue_o    (wr_issue),
        .rd_issue_o    (rd_issue),
        .dfi_cs_n_o    (dfi_cs_n_o),
        .dfi_ras_n_o   (dfi_ras_n_o),
        .dfi_cas_n_o   (dfi_cas_n_o),
        .dfi_we_n_o    (dfi_we_n_o),
        .dfi_cke_o     (dfi_cke_o),
        .dfi_address_o (dfi_address_o),
        .dfi_bank_o    (dfi_bank_o),
        .tmr_if        (tmr_if.ctrl)
    );

    //----------------------------------------------------------------------
    // Data paths
    //----------------------------------------------------------------------
    ddr3_wr_path u_wr_path (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .wr_issue_i        (wr_issue),
        .wrdata_i          (wrdata_i),
        .wrdata_mask_i     (wrdata_mask_i),
        .dfi_wrdata_o      (dfi_wrdata_o),
        .dfi_wrdata_mask_o (dfi_wrdata_mask_o),
        .dfi_wrdata_en_o   (dfi_wrdata_en_o)
    );

    ddr3_rd_path u_rd_path (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .rd_issue_i         (rd_issue),
        .dfi_rddata_valid_i (dfi_rddata_valid_i),
        .dfi_rddata_i       (dfi_rddata_i),
        .dfi_rddata_en_o    (dfi_rddata_en_o),
        .rddata_o           (rddata_o),
        .rddata_valid_o     (rddata_valid_o)
    );

endmodule

// ==== bench/tb_ddr3_dfi_seq.sv ====
// Expected timing follows the fixed package constants and all random data comes from one LFSR seed
module tb_ddr3_dfi_seq;

    import ddr3_seq_pkg::*;

    localparam int SLOTS       = 64;
    localparam int CMD_TIMEOUT = 64;

    logic        clk;
    logic        rst;
    cmd_t        command;
    row_addr_t   address;
    bank_t       bank;
    logic        cke;
    word_t       wrdata;
    word_mask_t  wrdata_mask;
    logic        accept;
    word_t       rddata;
    logic        rddata_valid;
    row_addr_t   dfi_address;
    bank_t       dfi_bank;
    logic        dfi_cs_n;
    logic        dfi_ras_n;
    logic        dfi_cas_n;
    logic        dfi_we_n;
    logic        dfi_cke;
    beat_t       dfi_wrdata;
    beat_mask_t  dfi_wrdata_mask;
    logic        dfi_wrdata_en;
    logic        dfi_rddata_en;
    beat_t       dfi_rddata;
    logic        dfi_rddata_valid;

    // Expected DFI command state after the last edge
    cmd_t        exp_cmd;
    row_addr_t   exp_addr;
    bank_t       exp_bank;
    logic        exp_cke;
    word_t       exp_rd_word;

    // Data-path events indexed by edge count modulo SLOTS
    logic        wr_en_sched    [SLOTS];
    beat_t       wr_data_sched  [SLOTS];
    beat_mask_t  wr_mask_sched  [SLOTS];
    logic        rd_en_sched    [SLOTS];
    logic        rd_valid_sched [SLOTS];

    int          cycle_no;
    logic        last_accept;
    logic [31:0] lfsr_q;

    ddr3_dfi_seq u_dut (
        .clk_i              (clk),
        .rst_i              (rst),
        .command_i          (command),
        .address_i          (address),
        .bank_i             (bank),
        .cke_i              (cke),
        .wrdata_i           (wrdata),
        .wrdata_mask_i      (wrdata_mask),
        .accept_o           (accept),
        .rddata_o           (rddata),
        .rddata_valid_o     (rddata_valid),
        .dfi_address_o      (dfi_address),
        .dfi_bank_o         (dfi_bank),
        .dfi_cs_n_o         (dfi_cs_n),
        .dfi_ras_n_o        (dfi_ras_n),
        .dfi_cas_n_o        (dfi_cas_n),
        .dfi_we_n_o         (dfi_we_n),
        .dfi_cke_o          (dfi_cke),
        .dfi_wrdata_o       (dfi_wrdata),
        .dfi_wrdata_mask_o  (dfi_wrdata_mask),
        .dfi_wrdata_en_o    (dfi_wrdata_en),
        .dfi_rddata_en_o    (dfi_rddata_en),
        .dfi_rddata_i       (dfi_rddata),
        .dfi_rddata_valid_i (dfi_rddata_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Random source and error reporting
    //----------------------------------------------------------------------
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        next_lfsr = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit with the newest bit lowest
    function automatic logic [127:0] rand_bits(input int n);
        logic [127:0] r;
        int           i;
        r = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_q = next_lfsr(lfsr_q);
            r = {r[126:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_addr(input string name, input row_addr_t got, input row_addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_bank(input string name, input bank_t got, input bank_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_mask(input string name, input beat_mask_t got, input beat_mask_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("FAILED %s: got 0x%h, expected 0x%h at edge %0d",
                                    name, got, exp, cycle_no));
    endtask

    task automatic check_gap(input string what, input int got, input int exp);
        if (got != exp)
            stop_on_error($sformatf("%s was taken %0d cycles after the previous command, not %0d",
                                    what, got, exp));
    endtask

    //----------------------------------------------------------------------
    // Cycle stepping
    //----------------------------------------------------------------------
    // Checks every output at the falling edge and moves on to the next rising edge
    task automatic step_cycle();
        int         slot;
        int         k;
        logic       took;
        cmd_t       cap_cmd;
        row_addr_t  cap_addr;
        bank_t      cap_bank;
        logic       cap_cke;
        word_t      cap_word;
        word_mask_t cap_mask;
        @(negedge clk);
        slot = cycle_no % SLOTS;
        check_cmd("dfi_cmd", cmd_t'({dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n}), exp_cmd);
        check_addr("dfi_address_o", dfi_address, exp_addr);
        check_bank("dfi_bank_o", dfi_bank, exp_bank);
        check_bit("dfi_cke_o", dfi_cke, exp_cke);
        check_bit("dfi_wrdata_en_o", dfi_wrdata_en, wr_en_sched[slot]);
        check_beat("dfi_wrdata_o", dfi_wrdata, wr_data_sched[slot]);
        check_mask("dfi_wrdata_mask_o", dfi_wrdata_mask, wr_mask_sched[slot]);
        check_bit("dfi_rddata_en_o", dfi_rddata_en, rd_en_sched[slot]);
        check_bit("rddata_valid_o", rddata_valid, rd_valid_sched[slot]);
        if (rd_valid_sched[slot])
            check_word("rddata_o", rddata, exp_rd_word);
        // NOP never waits
        if (command == CMD_NOP)
            check_bit("accept_o", accept, 1'b1);
        wr_en_sched[slot]    = 1'b0;
        wr_data_sched[slot]  = '0;
        wr_mask_sched[slot]  = '0;
        rd_en_sched[slot]    = 1'b0;
        rd_valid_sched[slot] = 1'b0;
        took     = accept;
        cap_cmd  = command;
        cap_addr = address;
        cap_bank = bank;
        cap_cke  = cke;
        cap_word = wrdata;
        cap_mask = wrdata_mask;
        @(posedge clk);
        cycle_no++;
        exp_cke  = cap_cke;
        exp_cmd  = took ? cap_cmd : CMD_NOP;
        exp_addr = took ? cap_addr : '0;
        exp_bank = took ? cap_bank : '0;
        // Write beats start PHY_WRLAT+1 edges after the accept with the low slice first
        if (took && (cap_cmd == CMD_WRITE))
        begin
            for (k = 0; k < BURST_LEN; k++)
            begin
                slot = (cycle_no + PHY_WRLAT + 1 + k) % SLOTS;
                wr_en_sched[slot]   = 1'b1;
                wr_data_sched[slot] = cap_word[32*k +: 32];
                wr_mask_sched[slot] = cap_mask[4*k +: 4];
            end
        end
        // Read enable window opens PHY_RDLAT+1 edges after the accept
        if (took && (cap_cmd == CMD_READ))
        begin
            for (k = 0; k < BURST_LEN; k++)
                rd_en_sched[(cycle_no + PHY_RDLAT + 1 + k) % SLOTS] = 1'b1;
        end
        last_accept = took;
    endtask

    task automatic idle_cycles(input int n);
        command <= CMD_NOP;
        address <= '0;
        bank    <= '0;
        repeat (n) step_cycle();
    endtask

    // Holds the command until taken; waited counts edges since the drive
    task automatic issue_cmd(input cmd_t cmd, input row_addr_t addr, input bank_t ba,
                             output int waited);
        command <= cmd;
        address <= addr;
        bank    <= ba;
        waited = 0;
        last_accept = 1'b0;
        while (!last_accept)
        begin
            if (waited >= CMD_TIMEOUT)
                stop_on_error($sformatf("%s was not accepted within %0d cycles",
                                        cmd.name(), CMD_TIMEOUT));
            step_cycle();
            waited++;
        end
        command <= CMD_NOP;
        address <= '0;
        bank    <= '0;
    endtask

    // Write word and mask ride along with the held WRITE
    task automatic issue_write(input word_t w, input word_mask_t m, input row_addr_t addr,
                               output int waited);
        wrdata      <= w;
        wrdata_mask <= m;
        issue_cmd(CMD_WRITE, addr, 3'd1, waited);
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic run_reset_checks();
        step_cycle();
        cke <= 1'b1;
        // cke still low on the first edge and high one edge later
        step_cycle();
        step_cycle();
    endtask

    task automatic active_then_read();
        int gap;
        issue_cmd(CMD_ACTIVE, 15'h1a5c, 3'd2, gap);
        // Timer reads expired after reset
        check_gap("ACTIVE after reset", gap, 1);
        issue_cmd(CMD_READ, 15'h0040, 3'd2, gap);
        check_gap("READ after ACTIVE", gap, TRCD_CYCLES + 1);
        idle_cycles(2);
    endtask

    task automatic refresh_then_precharge();
        int gap;
        issue_cmd(CMD_REFRESH, 15'h0000, 3'd0, gap);
        issue_cmd(CMD_PRECHARGE, 15'h0400, 3'd5, gap);
        check_gap("PRECHARGE after REFRESH", gap, TRFC_CYCLES + 1);
        issue_cmd(CMD_ACTIVE, 15'h7ff1, 3'd5, gap);
        check_gap("ACTIVE after PRECHARGE", gap, TRP_CYCLES + 1);
        idle_cycles(2);
    endtask

    task automatic single_write_burst();
        int gap;
        issue_write(word_t'(rand_bits(128)), word_mask_t'(rand_bits(16)), 15'h0088, gap);
        idle_cycles(PHY_WRLAT + BURST_LEN + 2);
    endtask

    task automatic back_to_back_writes();
        int gap;
        issue_write(word_t'(rand_bits(128)), word_mask_t'(rand_bits(16)), 15'h0100, gap);
        issue_write(word_t'(rand_bits(128)), word_mask_t'(rand_bits(16)), 15'h0108, gap);
        // Timer falls from RW_NONSEQ_CYCLES+1 to the sequential point
        check_gap("second WRITE", gap, RW_NONSEQ_CYCLES + 1 - RW_SEQ_CYCLES);
        issue_cmd(CMD_READ, 15'h0100, 3'd1, gap);
        check_gap("READ after WRITE", gap, RW_NONSEQ_CYCLES + 1);
        idle_cycles(PHY_RDLAT + BURST_LEN + 2);
    endtask

    task automatic read_burst_capture();
        int    gap;
        int    i;
        beat_t beats [BURST_LEN];
        issue_cmd(CMD_READ, 15'h0200, 3'd3, gap);
        idle_cycles(PHY_RDLAT + BURST_LEN + 1);
        for (i = 0; i < BURST_LEN; i++)
        begin
            beats[i] = beat_t'(rand_bits(32));
            dfi_rddata       <= beats[i];
            dfi_rddata_valid <= 1'b1;
            step_cycle();
        end
        // Word shows right after the edge that took the fourth beat
        exp_rd_word = {beats[3], beats[2], beats[1], beats[0]};
        rd_valid_sched[cycle_no % SLOTS] = 1'b1;
        dfi_rddata       <= '0;
        dfi_rddata_valid <= 1'b0;
        idle_cycles(3);
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial
    begin
        rst              = 1'b1;
        command          = CMD_NOP;
        address          = '0;
        bank             = '0;
        cke              = 1'b0;
        wrdata           = '0;
        wrdata_mask      = '0;
        dfi_rddata       = '0;
        dfi_rddata_valid = 1'b0;
        exp_cmd          = CMD_NOP;
        exp_addr         = '0;
        exp_bank         = '0;
        exp_cke          = 1'b0;
        exp_rd_word      = '0;
        cycle_no         = 0;
        last_accept      = 1'b0;
        lfsr_q           = 32'h88cf_6f7b;
        for (int s = 0; s < SLOTS; s++)
        begin
            wr_en_sched[s]    = 1'b0;
            wr_data_sched[s]  = '0;
            wr_mask_sched[s]  = '0;
            rd_en_sched[s]    = 1'b0;
            rd_valid_sched[s] = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        run_reset_checks();
        active_then_read();
        refresh_then_precharge();
        single_write_burst();
        back_to_back_writes();
        read_burst_capture();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== src.f ====
hw/ddr3_seq_pkg.sv
hw/ddr3_timer_if.sv
hw/ddr3_delay_timer.sv
hw/ddr3_cmd_sequencer.sv
hw/ddr3_wr_fifo.sv
hw/ddr3_wr_path.sv
hw/ddr3_rd_path.sv
hw/ddr3_dfi_seq.sv
bench/tb_ddr3_dfi_seq.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ddr3_dfi_seq \
    -f src.f -o tb_ddr3_dfi_seq > build.log 2>&1 ||
    { cat build.log; echo "Build error"; exit 1; }

./obj_dir/tb_ddr3_dfi_seq > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Test passed" sim.log && echo "Simulation PASSED" ||
    { echo "Simulation FAILED"; exit 1; }
